/* compile.f */
hdl/clkctl_pkg.sv
hdl/lock_timer.sv
hdl/lock_sequencer.sv
hdl/clk_postscaler.sv
hdl/clk_and_control.sv
hdl/clkctl_top.sv
dv/clkctl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the clock-control testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module clkctl_tb -f compile.f -o clkctl_sim

./obj_dir/clkctl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* dv/clkctl_tb.sv */
// random-stimulus testbench for the clock-control block, with a cycle model of
// the registers, LOCK and FLLCLK checked on every falling edge
`timescale 1ns/1ps
`default_nettype none

module clkctl_tb;

  import clkctl_pkg::*;

  localparam int WATCHDOG_CYCLES = 200 * 600;  // transactions times worst-case cycles
  localparam int ACK_TIMEOUT     = 8;
  localparam int LOCK_TIMEOUT    = 600;

  logic        clk;
  logic        RSTB;
  logic        CFGREQ;
  logic        CFGWEB;
  cfg_addr_t   CFGAD;
  logic [31:0] CFGD;
  logic [31:0] CFGQ;
  logic        CFGACK;
  logic        LOCK;
  logic        FLLCLK;

  logic [31:0] m_reg [0:3];  // register model
  logic [2:0]  m_lf_hi;      // loop-filter 34:32
  logic        m_ack;
  logic        m_relock;     // reg-1 write seen, acts at next edge
  logic        m_held;       // pll model in reset
  logic        m_lock;
  int          m_age;        // edges since the lock wait began
  int          m_n;          // lock-detect count taken at start
  int          m_run_cnt;    // cycles the divider has run

  int unsigned seed;
  cfg_addr_t   a;
  logic [31:0] d;
  logic [31:0] d0;
  logic [31:0] d1;
  logic [1:0]  l1;
  logic [7:0]  l2;
  int          n;
  int          per;

  clkctl_top #(.TIMER_W(10)) i_dut (
    .clk, .RSTB, .CFGREQ, .CFGWEB, .CFGAD, .CFGD,
    .CFGQ, .CFGACK, .LOCK, .FLLCLK
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $fatal(1);
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("mismatch %s expected 0x%0h got 0x%0h", name, exp, got);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // register 2 comes back with live LOCK and latched bit 32 on top
  function automatic logic [31:0] read_view(input cfg_addr_t addr);
    cfg2_u v;
    v          = m_reg[2];
    v.rd.lock  = m_lock;
    v.rd.lf_32 = m_lf_hi[0];
    case (addr)
      CFG0_ADDR: return m_reg[0];
      CFG1_ADDR: return m_reg[1];
      CFG2_ADDR: return v;
      CFG3_ADDR: return m_reg[3];
      default:   return '0;
    endcase
  endfunction

  // one clock, model stepped over the rising edge just passed
  task automatic next_cycle();
    logic rstn;
    logic wr;
    logic run;
    logic fll_exp;
    int   p;
    @(negedge clk);
    rstn = m_reg[0][2];          // pll reset bit as the edge saw it
    wr   = CFGREQ & ~CFGWEB;
    if (!rstn) begin
      m_held = 1'b1;
      m_lock = 1'b0;
    end else if (m_held || m_relock) begin
      m_held = 1'b0;             // wait (re)starts on this edge
      m_age  = 0;
      m_lock = 1'b0;
      m_n    = int'(m_reg[2][8:0]);
    end else begin
      m_age  = m_age + 1;
      m_lock = (m_age >= m_n + 2);
    end
    m_relock = wr & (CFGAD == CFG1_ADDR);
    if (wr && CFGAD <= CFG3_ADDR) begin
      if (CFGAD == CFG3_ADDR) begin
        m_lf_hi = m_reg[2][31:29];  // old reg-2 top bits
      end
      m_reg[CFGAD[1:0]] = CFGD;
    end
    m_ack = CFGREQ;
    p   = (int'(m_reg[0][11:4]) + 1) << m_reg[0][1:0];  // (L2+1) * 2**L1
    run = m_lock & m_reg[1][0] & ~m_reg[1][2];
    if (m_reg[1][2]) begin
      fll_exp = m_lock & m_reg[1][0];  // bypass level
    end else begin
      fll_exp = run && (m_run_cnt % p == p - 1);
    end
    m_run_cnt = run ? m_run_cnt + 1 : 0;
    assert (CFGACK === m_ack) else report_mismatch("CFGACK", 32'(m_ack), 32'(CFGACK));
    assert (LOCK === m_lock) else report_mismatch("LOCK", 32'(m_lock), 32'(LOCK));
    assert (FLLCLK === fll_exp) else report_mismatch("FLLCLK", 32'(fll_exp), 32'(FLLCLK));
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) next_cycle();
  endtask

  task automatic wait_ack(input logic level);
    int k;
    k = 0;
    while (CFGACK !== level) begin
      assert (k < ACK_TIMEOUT) else report_failure("CFGACK did not change within the timeout");
      next_cycle();
      k++;
    end
  endtask

  task automatic wait_lock(input logic level);
    int k;
    k = 0;
    while (LOCK !== level) begin
      assert (k < LOCK_TIMEOUT) else report_failure("LOCK did not change within the timeout");
      next_cycle();
      k++;
    end
  endtask

  task automatic bus_write(input cfg_addr_t addr, input logic [31:0] data);
    wait_ack(1'b0);  // previous access closed
    CFGREQ = 1'b1;
    CFGWEB = 1'b0;
    CFGAD  = addr;
    CFGD   = data;
    wait_ack(1'b1);
    CFGREQ = 1'b0;   // ack drops one cycle later
  endtask

  task automatic read_check(input cfg_addr_t addr);
    logic [31:0] exp;
    wait_ack(1'b0);
    CFGREQ = 1'b1;
    CFGWEB = 1'b1;
    CFGAD  = addr;
    exp    = read_view(addr);  // LOCK as the request edge samples it
    wait_ack(1'b1);
    assert (CFGQ === exp) else report_mismatch("CFGQ", exp, CFGQ);
    CFGREQ = 1'b0;
  endtask

  initial begin
    seed      = $urandom(47);
    RSTB      = 1'b0;
    CFGREQ    = 1'b0;
    CFGWEB    = 1'b1;
    CFGAD     = '0;
    CFGD      = '0;
    m_reg[0]  = CFG0_RST;
    m_reg[1]  = CFG1_RST;
    m_reg[2]  = CFG2_RST;
    m_reg[3]  = CFG3_RST;
    m_lf_hi   = '0;
    m_ack     = 1'b0;
    m_relock  = 1'b0;
    m_held    = 1'b1;
    m_lock    = 1'b0;
    m_age     = 0;
    m_n       = 0;
    m_run_cnt = 0;
    repeat (16) @(negedge clk);
    RSTB = 1'b1;

    for (int i = 0; i < 4; i++) begin  // reset words
      read_check(cfg_addr_t'(i));
    end
    idle(4);

    repeat (60) begin                  // register traffic, pll held
      a = cfg_addr_t'($urandom_range(3, 0));
      d = $urandom;
      if (a == CFG0_ADDR) begin
        d[2] = 1'b0;
      end
      bus_write(a, d);
      read_check(a);
    end
    bus_write(CFG2_ADDR, $urandom);
    bus_write(CFG3_ADDR, $urandom);    // latches reg-2 top bits
    read_check(CFG2_ADDR);

    repeat (6) begin                   // lock timing, relock, divider
      n     = int'($urandom_range(20, 0));
      l1    = 2'($urandom_range(3, 0));
      l2    = 8'($urandom_range(255, 0));
      per   = (int'(l2) + 1) << l1;
      d     = $urandom;
      d[8:0] = 9'(n);
      bus_write(CFG2_ADDR, d);
      d1    = $urandom;
      d1[0] = 1'b1;                    // enable
      d1[2] = 1'b0;                    // divided output
      bus_write(CFG1_ADDR, d1);
      d0       = $urandom;
      d0[1:0]  = l1;
      d0[2]    = 1'b1;                 // release pll model
      d0[11:4] = l2;
      bus_write(CFG0_ADDR, d0);
      wait_lock(1'b1);
      idle(2 * per + 3);
      read_check(CFG2_ADDR);           // LOCK visible in read view
      bus_write(CFG1_ADDR, d1);        // multiplier rewrite
      wait_lock(1'b0);
      wait_lock(1'b1);
      idle(per + 2);
      bus_write(CFG0_ADDR, d0 & ~32'h4);
      wait_lock(1'b0);
      idle(3);
    end

    d1    = $urandom;                  // bypass
    d1[0] = 1'b1;
    d1[2] = 1'b1;
    bus_write(CFG1_ADDR, d1);
    d0    = $urandom;
    d0[2] = 1'b1;
    bus_write(CFG0_ADDR, d0);
    wait_lock(1'b1);
    idle(20);
    repeat (8) begin
      d1[0] = ~d1[0];                  // toggle enable, relocks
      bus_write(CFG1_ADDR, d1);
      wait_lock(1'b0);
      wait_lock(1'b1);
      idle(int'($urandom_range(20, 1)));
    end
    bus_write(CFG0_ADDR, d0 & ~32'h4);
    wait_lock(1'b0);
    idle(10);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/clkctl_top.sv */
// clock-generator control top, register file plus the behavioral pll model
// TIMER_W sizes the lock timer and must cover the lock-detect count
`timescale 1ns/1ps
`default_nettype none

module clkctl_top #(
  parameter int TIMER_W = 10
) (
  input  wire logic                  clk,
  input  wire logic                  RSTB,
  input  wire logic                  CFGREQ,
  input  wire logic                  CFGWEB,
  input  wire clkctl_pkg::cfg_addr_t CFGAD,
  input  wire logic [31:0]           CFGD,
  output logic [31:0]                CFGQ,
  output logic                       CFGACK,
  output logic                       LOCK,
  output logic                       FLLCLK
);

  import clkctl_pkg::*;

  logic              pll_rstn;
  logic              ps_en;
  logic              ps_bypass;
  logic [L1_W-1:0]   ps_l1;
  logic [L2_W-1:0]   ps_l2;
  logic [LDET_W-1:0] ldet_count;
  logic              relock_req;
  logic              timer_load;
  logic              timer_count_en;
  logic [TIMER_W-1:0] timer_value;
  logic              timer_done;

  clk_and_control i_regs (
    .clk, .RSTB, .CFGREQ, .CFGWEB, .CFGAD, .CFGD, .LOCK,
    .CFGACK, .CFGQ, .pll_rstn, .ps_en, .ps_bypass, .ps_l1, .ps_l2,
    .ldet_count, .relock_req
  );

  lock_sequencer #(.TIMER_W(TIMER_W)) i_seq (
    .clk, .RSTB, .pll_rstn, .relock_req, .ldet_count, .timer_done,
    .timer_load, .timer_count_en, .timer_value, .LOCK
  );

  lock_timer #(.TIMER_W(TIMER_W)) i_timer (
    .clk, .RSTB,
    .load       (timer_load),
    .count_en   (timer_count_en),
    .load_value (timer_value),
    .done       (timer_done)
  );

  clk_postscaler i_ps (
    .clk, .RSTB,
    .lock (LOCK),
    .ps_en, .ps_bypass, .ps_l1, .ps_l2, .FLLCLK
  );

endmodule

`default_nettype wire

/* hdl/clk_and_control.sv */
// configuration register file behind the CFGREQ/CFGACK level handshake
// decodes the fields that drive the pll model and post-scaler
`timescale 1ns/1ps
`default_nettype none

module clk_and_control (
  input  wire logic                              clk,
  input  wire logic                              RSTB,
  input  wire logic                              CFGREQ,
  input  wire logic                              CFGWEB,      // high = read
  input  wire clkctl_pkg::cfg_addr_t             CFGAD,
  input  wire logic [31:0]                       CFGD,
  input  wire logic                              LOCK,
  output logic                                   CFGACK,
  output logic [31:0]                            CFGQ,
  output logic                                   pll_rstn,
  output logic                                   ps_en,
  output logic                                   ps_bypass,
  output logic [clkctl_pkg::L1_W-1:0]            ps_l1,
  output logic [clkctl_pkg::L2_W-1:0]            ps_l2,
  output logic [clkctl_pkg::LDET_W-1:0]          ldet_count,
  output logic                                   relock_req   // multiplier changed
);

  import clkctl_pkg::*;

  logic [31:0] config0;
  logic [31:0] config1;
  cfg2_u       config2;
  logic [31:0] config3;
  logic [2:0]  lf_hi_q;   // loop-filter 34:32, taken from cfg2 on cfg3 write
  cfg2_u       cfg2_rd;   // register 2 read word
  logic [31:0] rd_word;
  logic        wr_acc;
  logic        rd_acc;

  assign wr_acc = CFGREQ & ~CFGWEB;
  assign rd_acc = CFGREQ & CFGWEB;

  // field decode
  assign pll_rstn   = RSTB & config0[2];  // pll released only out of reset
  assign ps_l1      = config0[1:0];
  assign ps_l2      = config0[11:4];
  assign ps_en      = config1[0];
  assign ps_bypass  = config1[2];
  assign ldet_count = config2.wr.ldet;

  always_comb begin
    cfg2_rd          = config2;
    cfg2_rd.rd.lock  = LOCK;        // top bits replaced on read
    cfg2_rd.rd.lf_32 = lf_hi_q[0];
  end

  always_comb begin
    case (CFGAD)
      CFG0_ADDR: rd_word = config0;
      CFG1_ADDR: rd_word = config1;
      CFG2_ADDR: rd_word = cfg2_rd;
      CFG3_ADDR: rd_word = config3;
      default:   rd_word = '0;  // unmapped reads as zero
    endcase
  end

  // register writes, repeated harmlessly while CFGREQ stays high
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      config0 <= CFG0_RST;
      config1 <= CFG1_RST;
      config2 <= CFG2_RST;
      config3 <= CFG3_RST;
      lf_hi_q <= '0;
    end else if (wr_acc) begin
      case (CFGAD)
        CFG0_ADDR: config0 <= CFGD;
        CFG1_ADDR: config1 <= CFGD;
        CFG2_ADDR: config2 <= CFGD;
        CFG3_ADDR: begin
          config3 <= CFGD;
          lf_hi_q <= config2.wr.lf_hi;  // old cfg2 top bits
        end
        default: ;                      // unmapped, dropped
      endcase
    end
  end

  // handshake and read data
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      CFGACK     <= 1'b0;
      CFGQ       <= '0;
      relock_req <= 1'b0;
    end else begin
      CFGACK     <= CFGREQ;                                   // level ack
      relock_req <= wr_acc & (CFGAD == CFG1_ADDR) & ~CFGACK;  // first ack cycle only
      if (rd_acc) begin
        CFGQ <= rd_word;
      end
    end
  end

  // held request keeps its fields, so the repeated access is harmless
  a_req_held_stable: assert property (@(posedge clk) disable iff (!RSTB)
    CFGREQ && CFGACK |-> $stable(CFGWEB) && $stable(CFGAD) && $stable(CFGD))
    else $error("CFGREQ fields changed while the request was held");

  // relock comes from a write, never with a read in flight
  a_relock_not_read: assert property (@(posedge clk) disable iff (!RSTB)
    relock_req |-> !(CFGREQ && CFGWEB))
    else $error("relock_req during a read request");

endmodule

`default_nettype wire

/* hdl/clk_postscaler.sv */
// post-scaler for the pll model, divides by 2**L1 then by L2+1
// output is a one-cycle enable pulse, or a level in bypass
`timescale 1ns/1ps
`default_nettype none

module clk_postscaler (
  input  wire logic                        clk,
  input  wire logic                        RSTB,
  input  wire logic                        lock,
  input  wire logic                        ps_en,
  input  wire logic                        ps_bypass,
  input  wire logic [clkctl_pkg::L1_W-1:0] ps_l1,
  input  wire logic [clkctl_pkg::L2_W-1:0] ps_l2,
  output logic                             FLLCLK
);

  logic                        active;    // locked and enabled
  logic                        run;       // dividers counting
  logic [2:0]                  pre_q;     // up to 2**3-1 for L1=3
  logic [2:0]                  pre_max;
  logic [clkctl_pkg::L2_W-1:0] div_q;
  logic                        pre_tick;
  logic                        div_tick;

  assign active  = lock & ps_en;
  assign run     = active & ~ps_bypass;
  assign pre_max = ~(3'b111 << ps_l1);  // 2**L1 - 1

  // >= so a smaller field written mid-count wraps at once
  assign pre_tick = (pre_q >= pre_max);
  assign div_tick = pre_tick & (div_q >= ps_l2);

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      pre_q <= '0;
      div_q <= '0;
    end else if (!run) begin
      pre_q <= '0;                      // idle or bypass, restart clean
      div_q <= '0;
    end else begin
      if (pre_tick) begin
        pre_q <= '0;
      end else begin
        pre_q <= pre_q + 1'b1;
      end
      if (div_tick) begin
        div_q <= '0;
      end else if (pre_tick) begin
        div_q <= div_q + 1'b1;          // one step per prescale period
      end
    end
  end

  // bypass passes the gate straight through
  assign FLLCLK = ps_bypass ? active : (run & div_tick);

endmodule

`default_nettype wire

/* hdl/lock_sequencer.sv */
// lock sequencer for the pll model, holds it in reset, times the lock wait
// and restarts the wait when the multiplier is rewritten
`timescale 1ns/1ps
`default_nettype none

module lock_sequencer #(
  parameter int TIMER_W = 10   // at least LDET_W
) (
  input  wire logic                              clk,
  input  wire logic                              RSTB,
  input  wire logic                              pll_rstn,
  input  wire logic                              relock_req,
  input  wire logic [clkctl_pkg::LDET_W-1:0]     ldet_count,
  input  wire logic                              timer_done,
  output logic                                   timer_load,
  output logic                                   timer_count_en,
  output logic [TIMER_W-1:0]                     timer_value,
  output logic                                   LOCK
);

  import clkctl_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      HELD: begin
        if (pll_rstn) state_d = WAIT_LOCK;  // timer loaded on this edge
      end
      WAIT_LOCK: begin
        if (!pll_rstn) begin
          state_d = HELD;
        end else if (relock_req) begin
          state_d = WAIT_LOCK;              // reload, wait again
        end else if (timer_done) begin
          state_d = LOCKED;
        end
      end
      LOCKED: begin
        if (!pll_rstn) begin
          state_d = HELD;
        end else if (relock_req) begin
          state_d = WAIT_LOCK;
        end
      end
      default: state_d = HELD;
    endcase
  end

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      state_q <= HELD;
    end else begin
      state_q <= state_d;
    end
  end

  // load and count never overlap
  assign timer_load     = pll_rstn & ((state_q == HELD) | relock_req);
  assign timer_count_en = pll_rstn & (state_q == WAIT_LOCK) & ~relock_req;
  assign timer_value    = TIMER_W'(ldet_count);  // zero-extended
  assign LOCK           = (state_q == LOCKED);

  // lock dropped on the cycle after the pll is put back in reset
  a_lock_needs_rstn: assert property (@(posedge clk) disable iff (!RSTB)
    !pll_rstn |=> !LOCK)
    else $error("LOCK outlived pll_rstn");

endmodule

`default_nettype wire

/* hdl/lock_timer.sv */
// loadable down-counter for the lock-detect interval
// done goes high one cycle after the count has reached zero
`timescale 1ns/1ps
`default_nettype none

module lock_timer #(
  parameter int TIMER_W = 10
) (
  input  wire logic               clk,
  input  wire logic               RSTB,
  input  wire logic               load,
  input  wire logic               count_en,
  input  wire logic [TIMER_W-1:0] load_value,
  output logic                    done
);

  logic [TIMER_W-1:0] cnt_q;
  logic               done_q;   // held until next load

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (load) begin
      cnt_q  <= load_value;
      done_q <= 1'b0;
    end else if (count_en) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        done_q <= 1'b1;           // zero seen while counting
      end
    end
  end

  assign done = done_q & count_en;  // only reported while the wait runs

  // sequencer keeps load and counting apart
  a_load_not_done: assert property (@(posedge clk) disable iff (!RSTB)
    !(load && done))
    else $error("timer load while done");

endmodule

`default_nettype wire

/* hdl/clkctl_pkg.sv */
// shared definitions for the clock-generator control block
// register map, reset words, field widths, register-2 views, sequencer states
`default_nettype none

package clkctl_pkg;

  localparam int LDET_W = 9;  // lock-detect count
  localparam int L1_W   = 2;  // power-of-two post-divider
  localparam int L2_W   = 8;  // linear post-divider

  typedef logic [3:0] cfg_addr_t;  // as seen on CFGAD

  localparam cfg_addr_t CFG0_ADDR = 4'd0;  // post-scaler and pll reset
  localparam cfg_addr_t CFG1_ADDR = 4'd1;  // enable, bypass, multiplier
  localparam cfg_addr_t CFG2_ADDR = 4'd2;  // lock detect and ssc
  localparam cfg_addr_t CFG3_ADDR = 4'd3;  // loop filter low word

  localparam logic [31:0] CFG0_RST = 32'h0000_0000;  // pll held, L1=0 L2=0
  localparam logic [31:0] CFG1_RST = 32'h0000_0004;  // bypass on, output off
  localparam logic [31:0] CFG2_RST = 32'h0000_0064;  // ldet 100, ssc off
  localparam logic [31:0] CFG3_RST = 32'h0000_0269;

  // register 2 as written by the host
  typedef struct packed {
    logic [2:0]        lf_hi;       // copied to loop-filter 34:32 on cfg3 write
    logic [10:0]       ssc_period;
    logic [7:0]        ssc_step;
    logic              ssc_en;
    logic [LDET_W-1:0] ldet;        // lock-detect count
  } cfg2_wr_t;

  // register 2 as returned to the host
  typedef struct packed {
    logic        lock;    // live LOCK
    logic        lf_32;   // latched loop-filter bit 32
    logic [29:0] stored;  // stored bits below
  } cfg2_rd_t;

  typedef union packed {
    cfg2_wr_t wr;
    cfg2_rd_t rd;
  } cfg2_u;

  // lock sequencer states
  typedef enum logic [1:0] {
    HELD      = 2'd0,  // pll model in reset
    WAIT_LOCK = 2'd1,  // timer running
    LOCKED    = 2'd2
  } seq_state_t;

endpackage

`default_nettype wire
